/* hw/gfx_mapper_pkg.sv */
// graphics ROM bank mapper shared widths, vector types, layer codes and game ids
`default_nettype none

package gfx_mapper_pkg;

    // board layout is four ROM banks with a 4-bit slice each
    localparam int unsigned BANK_N  = 4;
    localparam int unsigned FIELD_W = 4;

    // tile address bits 22:20
    typedef logic [2:0] layer_t;

    // high tile-code bits, address 19:10
    typedef logic [9:0] code_t;

    // one bit per ROM bank
    typedef logic [BANK_N-1:0] bank_t;

    typedef logic [FIELD_W-1:0] field_t;

    // four slices packed, bank 0 in the low nibble
    typedef logic [BANK_N*FIELD_W-1:0] cfg_t;

    typedef logic [5:0] game_t;

    // layer codes
    localparam layer_t LAYER_OBJ  = 3'd0;
    localparam layer_t LAYER_SCR1 = 3'd1;
    localparam layer_t LAYER_SCR2 = 3'd2;
    localparam layer_t LAYER_SCR3 = 3'd3;
    localparam layer_t LAYER_STAR = 3'd4;

    // game ids in board numbering
    // any id not listed here selects no bank
    localparam game_t GAME_CAPTCOMM = 6'd2;
    localparam game_t GAME_FORGOTTN = 6'd8;
    localparam game_t GAME_GHOULS   = 6'd10;
    localparam game_t GAME_MEGAMAN  = 6'd14;
    localparam game_t GAME_SF2      = 6'd25;
    localparam game_t GAME_STRIDER  = 6'd29;

endpackage

`default_nettype wire

/* hw/pal_eq_region.sv */
// PAL bank equations for the games that decode mostly on the layer code
`default_nettype none
`timescale 1ns/1ps

module pal_eq_region (
    input  wire gfx_mapper_pkg::layer_t layer,
    input  wire gfx_mapper_pkg::code_t  code,
    output gfx_mapper_pkg::bank_t       ghouls_bank,
    output gfx_mapper_pkg::bank_t       forgottn_bank,
    output gfx_mapper_pkg::bank_t       strider_bank
);

    // PAL input pins
    wire i2 = layer[2];
    wire i3 = layer[1];
    wire i4 = layer[0];
    wire i5 = code[9];
    wire i6 = code[8];
    wire i8 = code[6];

    // strider splits on the odd scroll layers
    wire scr_odd = (layer == gfx_mapper_pkg::LAYER_SCR1) ||
                   (layer == gfx_mapper_pkg::LAYER_SCR3);

    // ghouls
    // bank 2 is OBJ upper half, bank 1 SCR3 lower half
    assign ghouls_bank = {
        1'b0,
        ~i2 & ~i3 & ~i4 & i8,
        ~i2 & i3 & i4 & ~i8,
        (~i2 & ~i3 & i4) |
        (~i2 & ~i4 & ~i8) |
        (~i2 & i3 & ~i4)
    };

    // forgottn
    // scroll 2 and star field share bank 1
    assign forgottn_bank = {
        2'b00,
        (~i2 & i3 & ~i4) |
        (i2 & ~i3 & ~i4),
        (~i2 & ~i3 & i4) |
        (~i2 & ~i3 & ~i5 & ~i6)
    };

    // strider
    assign strider_bank = {
        2'b00,
        scr_odd,
        ~scr_odd
    };

endmodule

`default_nettype wire

/* hw/pal_eq_code.sv */
// PAL bank equations for the games that decode on the high tile-code bits
`default_nettype none
`timescale 1ns/1ps

module pal_eq_code (
    input  wire gfx_mapper_pkg::layer_t layer,
    input  wire gfx_mapper_pkg::code_t  code,
    output gfx_mapper_pkg::bank_t       captcomm_bank,
    output gfx_mapper_pkg::bank_t       megaman_bank,
    output gfx_mapper_pkg::bank_t       sf2_bank
);

    // PAL input pins
    wire i2 = layer[2];
    wire i3 = layer[1];
    wire i4 = layer[0];
    wire i5 = code[9];
    wire i6 = code[8];
    wire i7 = code[7];
    wire i8 = code[6];

    // sprites decode on layer OBJ alone
    wire obj = ~i2 & ~i3 & ~i4;

    // captcomm
    // bank 1 for code page 01 on any tile layer
    assign captcomm_bank = {
        2'b00,
        ~i2 & ~i5 & i6,
        ~i2 & ~i4 & ~i5 & ~i6
    };

    // megaman
    // code[9:8] picks the bank directly
    assign megaman_bank = {
        i5 & i6,
        i5 & ~i6,
        ~i5 & i6,
        ~i5 & ~i6
    };

    // sf2
    // sprites split across banks 0 and 1 on code[9]
    // bank 2 terms never decode layer OBJ
    assign sf2_bank = {
        1'b0,
        (~i2 & ~i3 & i4 & ~i5 & ~i6 & ~i7) |
        (i2 & i3 & ~i4 & ~i5 & ~i6 & i7) |
        (~i2 & i3 & ~i4 & ~i5 & i6 & ~i7 & ~i8) |
        (i2 & ~i3 & ~i4 & ~i5 & i6 & ~i7 & i8) |
        (i2 & ~i3 & ~i4 & ~i5 & i6 & i7),
        obj & i5,
        obj & ~i5
    };

endmodule

`default_nettype wire

/* hw/bank_latch.sv */
// bank choice register, loads the current game's candidate while enable is high
`default_nettype none
`timescale 1ns/1ps

module bank_latch (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        enable,
    input  wire gfx_mapper_pkg::game_t game,
    input  wire gfx_mapper_pkg::bank_t captcomm_bank,
    input  wire gfx_mapper_pkg::bank_t forgottn_bank,
    input  wire gfx_mapper_pkg::bank_t ghouls_bank,
    input  wire gfx_mapper_pkg::bank_t megaman_bank,
    input  wire gfx_mapper_pkg::bank_t sf2_bank,
    input  wire gfx_mapper_pkg::bank_t strider_bank,
    output gfx_mapper_pkg::bank_t      bank
);

    // enable low holds the last decision
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= '0;
        end else if (enable) begin
            case (game)
                gfx_mapper_pkg::GAME_CAPTCOMM: begin
                    bank <= captcomm_bank;
                end
                gfx_mapper_pkg::GAME_FORGOTTN: begin
                    bank <= forgottn_bank;
                end
                gfx_mapper_pkg::GAME_GHOULS: begin
                    bank <= ghouls_bank;
                end
                gfx_mapper_pkg::GAME_MEGAMAN: begin
                    bank <= megaman_bank;
                end
                gfx_mapper_pkg::GAME_SF2: begin
                    bank <= sf2_bank;
                end
                gfx_mapper_pkg::GAME_STRIDER: begin
                    bank <= strider_bank;
                end
                // unsupported titles map nothing
                default: begin
                    bank <= '0;
                end
            endcase
        end
    end

    // bank stays known once out of reset
    a_bank_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(bank)
    );

    // megaman and strider always land on exactly one bank
    a_onehot_games: assert property (
        @(posedge clk) disable iff (rst)
        enable && ((game == gfx_mapper_pkg::GAME_MEGAMAN) ||
                   (game == gfx_mapper_pkg::GAME_STRIDER))
        |=> $onehot(bank)
    );

endmodule

`default_nettype wire

/* hw/bank_window.sv */
// bank window, picks offset and mask slices for the latched bank
`default_nettype none
`timescale 1ns/1ps

module bank_window (
    input  wire gfx_mapper_pkg::bank_t bank,
    input  wire gfx_mapper_pkg::cfg_t  bank_offset,
    input  wire gfx_mapper_pkg::cfg_t  bank_mask,
    output gfx_mapper_pkg::field_t     offset,
    output gfx_mapper_pkg::field_t     mask,
    output logic                       unmapped
);

    localparam int unsigned W = gfx_mapper_pkg::FIELD_W;

    // one-hot bank k selects nibble k
    // anything else passes the full mask with no offset
    always_comb begin
        offset = '0;
        mask   = '1;
        case (bank)
            4'b0001: begin
                offset = bank_offset[0*W +: W];
                mask   = bank_mask[0*W +: W];
            end
            4'b0010: begin
                offset = bank_offset[1*W +: W];
                mask   = bank_mask[1*W +: W];
            end
            4'b0100: begin
                offset = bank_offset[2*W +: W];
                mask   = bank_mask[2*W +: W];
            end
            4'b1000: begin
                offset = bank_offset[3*W +: W];
                mask   = bank_mask[3*W +: W];
            end
            default: begin
                offset = '0;
                mask   = '1;
            end
        endcase
    end

    // multi-bit banks count as mapped
    assign unmapped = (bank == '0);

endmodule

`default_nettype wire

/* hw/gfx_mapper_top.sv */
// graphics ROM bank mapper top, PAL equations into the bank register and window
`default_nettype none
`timescale 1ns/1ps

module gfx_mapper_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         enable,
    input  wire gfx_mapper_pkg::game_t  game,
    input  wire gfx_mapper_pkg::cfg_t   bank_offset,
    input  wire gfx_mapper_pkg::cfg_t   bank_mask,
    input  wire gfx_mapper_pkg::layer_t layer,
    input  wire gfx_mapper_pkg::code_t  code,
    output wire gfx_mapper_pkg::field_t offset,
    output wire gfx_mapper_pkg::field_t mask,
    output wire                         unmapped
);

    // per-game candidates
    wire gfx_mapper_pkg::bank_t ghouls_bank;
    wire gfx_mapper_pkg::bank_t forgottn_bank;
    wire gfx_mapper_pkg::bank_t strider_bank;
    wire gfx_mapper_pkg::bank_t captcomm_bank;
    wire gfx_mapper_pkg::bank_t megaman_bank;
    wire gfx_mapper_pkg::bank_t sf2_bank;

    wire gfx_mapper_pkg::bank_t bank;

    pal_eq_region pal_eq_region_i (
        .layer         (layer),
        .code          (code),
        .ghouls_bank   (ghouls_bank),
        .forgottn_bank (forgottn_bank),
        .strider_bank  (strider_bank)
    );

    pal_eq_code pal_eq_code_i (
        .layer         (layer),
        .code          (code),
        .captcomm_bank (captcomm_bank),
        .megaman_bank  (megaman_bank),
        .sf2_bank      (sf2_bank)
    );

    // one cycle from sampled inputs to outputs
    bank_latch bank_latch_i (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .game          (game),
        .captcomm_bank (captcomm_bank),
        .forgottn_bank (forgottn_bank),
        .ghouls_bank   (ghouls_bank),
        .megaman_bank  (megaman_bank),
        .sf2_bank      (sf2_bank),
        .strider_bank  (strider_bank),
        .bank          (bank)
    );

    bank_window bank_window_i (
        .bank        (bank),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .offset      (offset),
        .mask        (mask),
        .unmapped    (unmapped)
    );

endmodule

`default_nettype wire

/* verification/gfx_mapper_tb.sv */
// graphics ROM bank mapper testbench, directed fetches checked against the per-game bank rules
`default_nettype none
`timescale 1ns/1ps

module gfx_mapper_tb;

    localparam int RESET_LIMIT = 40;
    localparam int W = gfx_mapper_pkg::FIELD_W;
    localparam gfx_mapper_pkg::cfg_t OFFSET_CFG = 16'h4321;
    localparam gfx_mapper_pkg::cfg_t MASK_CFG = 16'h8765;
    // dropped titles in board numbering
    localparam gfx_mapper_pkg::game_t GAME_DINO = 6'd5;
    localparam gfx_mapper_pkg::game_t GAME_MERCS = 6'd15;

    logic                        clk;
    logic                        rst;
    logic                        enable;
    gfx_mapper_pkg::game_t       game;
    gfx_mapper_pkg::cfg_t        bank_offset;
    gfx_mapper_pkg::cfg_t        bank_mask;
    gfx_mapper_pkg::layer_t      layer;
    gfx_mapper_pkg::code_t       code;
    wire gfx_mapper_pkg::field_t offset;
    wire gfx_mapper_pkg::field_t mask;
    wire                         unmapped;

    integer seed;
    int     checks;
    int     errors;
    int     test_checks;
    int     test_errors;
    logic   timed_out;

    gfx_mapper_top gfx_mapper_top_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .game        (game),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .layer       (layer),
        .code        (code),
        .offset      (offset),
        .mask        (mask),
        .unmapped    (unmapped)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

    function automatic gfx_mapper_pkg::code_t random_code();
        logic [31:0] r;
        r = $random(seed);
        return r[9:0];
    endfunction

    function automatic gfx_mapper_pkg::layer_t random_layer();
        logic [31:0] r;
        r = $random(seed);
        return 3'(r % 32'd5);
    endfunction

    // bank vector per game, straight from the equation rules
    function automatic gfx_mapper_pkg::bank_t expected_bank(
        input gfx_mapper_pkg::game_t  g,
        input gfx_mapper_pkg::layer_t l,
        input gfx_mapper_pkg::code_t  c
    );
        gfx_mapper_pkg::bank_t b;
        logic obj;
        logic scr1;
        logic scr2;
        logic scr3;
        logic star;
        logic [1:0] page;
        b    = '0;
        obj  = (l == gfx_mapper_pkg::LAYER_OBJ);
        scr1 = (l == gfx_mapper_pkg::LAYER_SCR1);
        scr2 = (l == gfx_mapper_pkg::LAYER_SCR2);
        scr3 = (l == gfx_mapper_pkg::LAYER_SCR3);
        star = (l == gfx_mapper_pkg::LAYER_STAR);
        page = c[9:8];
        case (g)
            gfx_mapper_pkg::GAME_GHOULS: begin
                b[2] = obj && c[6];
                b[1] = scr3 && !c[6];
                b[0] = scr1 || scr2 || ((obj || scr2) && !c[6]);
            end
            gfx_mapper_pkg::GAME_FORGOTTN: begin
                b[1] = scr2 || star;
                b[0] = scr1 || ((obj || scr1) && (page == 2'b00));
            end
            gfx_mapper_pkg::GAME_STRIDER: begin
                b[1] = scr1 || scr3;
                b[0] = !(scr1 || scr3);
            end
            gfx_mapper_pkg::GAME_MEGAMAN: begin
                b[page] = 1'b1;
            end
            gfx_mapper_pkg::GAME_CAPTCOMM: begin
                b[1] = (l < gfx_mapper_pkg::LAYER_STAR) && (page == 2'b01);
                b[0] = (obj || scr2) && (page == 2'b00);
            end
            // only sprite fetches are modelled, bank 2 never decodes OBJ
            gfx_mapper_pkg::GAME_SF2: begin
                b[1] = obj && c[9];
                b[0] = obj && !c[9];
            end
            default: begin
                b = '0;
            end
        endcase
        return b;
    endfunction

    task automatic expected_window(
        input  gfx_mapper_pkg::bank_t  b,
        output gfx_mapper_pkg::field_t off,
        output gfx_mapper_pkg::field_t msk,
        output logic                   unm
    );
        int k;
        off = '0;
        msk = 4'hf;
        unm = (b == '0);
        if ($countones(b) == 1) begin
            for (k = 0; k < gfx_mapper_pkg::BANK_N; k++) begin
                if (b[k]) begin
                    off = OFFSET_CFG[k*W +: W];
                    msk = MASK_CFG[k*W +: W];
                end
            end
        end
    endtask

    task automatic check_outputs(
        input string                  name,
        input gfx_mapper_pkg::field_t exp_off,
        input gfx_mapper_pkg::field_t exp_msk,
        input logic                   exp_unm
    );
        test_checks++;
        assert (offset === exp_off) else begin
            test_errors++;
            $display("[FAIL] %s offset expected %h actual %h", name, exp_off, offset);
        end
        assert (mask === exp_msk) else begin
            test_errors++;
            $display("[FAIL] %s mask expected %h actual %h", name, exp_msk, mask);
        end
        assert (unmapped === exp_unm) else begin
            test_errors++;
            $display("[FAIL] %s unmapped expected %b actual %b", name, exp_unm, unmapped);
        end
    endtask

    // one enabled edge, outputs read at the following falling edge
    task automatic apply_fetch(
        input gfx_mapper_pkg::game_t  g,
        input gfx_mapper_pkg::layer_t l,
        input gfx_mapper_pkg::code_t  c
    );
        @(posedge clk);
        game   <= g;
        layer  <= l;
        code   <= c;
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        @(negedge clk);
    endtask

    task automatic fetch_and_check(
        input string                  name,
        input gfx_mapper_pkg::game_t  g,
        input gfx_mapper_pkg::layer_t l,
        input gfx_mapper_pkg::code_t  c
    );
        gfx_mapper_pkg::field_t off;
        gfx_mapper_pkg::field_t msk;
        logic unm;
        apply_fetch(g, l, c);
        expected_window(expected_bank(g, l, c), off, msk, unm);
        check_outputs(name, off, msk, unm);
    endtask

    task automatic report_test(input string name);
        $display("%-18s %0d checks, %0d errors", name, test_checks, test_errors);
        checks += test_checks;
        errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic wait_reset_release(output logic expired);
        int n;
        n = 0;
        while (rst && (n < RESET_LIMIT)) begin
            @(posedge clk);
            n++;
        end
        expired = rst;
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_outputs("reset", 4'h0, 4'hf, 1'b1);
        report_test("reset");
    endtask

    task automatic megaman_banks();
        gfx_mapper_pkg::code_t c;
        int i;
        for (i = 0; i < 32; i++) begin
            c = random_code();
            fetch_and_check("megaman", gfx_mapper_pkg::GAME_MEGAMAN, random_layer(), c);
        end
        report_test("megaman");
    endtask

    task automatic strider_forgottn_layers();
        gfx_mapper_pkg::code_t c;
        int l;
        int i;
        for (l = 0; l < 5; l++) begin
            for (i = 0; i < 4; i++) begin
                c = random_code();
                fetch_and_check("strider", gfx_mapper_pkg::GAME_STRIDER, 3'(l), c);
                fetch_and_check("forgottn", gfx_mapper_pkg::GAME_FORGOTTN, 3'(l), c);
                // page 00 opens the extra OBJ and SCR1 term
                c[9:8] = 2'b00;
                fetch_and_check("forgottn", gfx_mapper_pkg::GAME_FORGOTTN, 3'(l), c);
            end
        end
        report_test("strider_forgottn");
    endtask

    task automatic captcomm_sf2_codes();
        gfx_mapper_pkg::code_t c;
        int l;
        int p;
        for (l = 0; l < 5; l++) begin
            for (p = 0; p < 4; p++) begin
                c = random_code();
                c[9:8] = 2'(p);
                fetch_and_check("captcomm", gfx_mapper_pkg::GAME_CAPTCOMM, 3'(l), c);
            end
        end
        // SCR3 on page 00 hits no term
        apply_fetch(gfx_mapper_pkg::GAME_CAPTCOMM, gfx_mapper_pkg::LAYER_SCR3, 10'h0a5);
        check_outputs("captcomm", 4'h0, 4'hf, 1'b1);
        for (p = 0; p < 8; p++) begin
            c = random_code();
            c[9] = p[0];
            fetch_and_check("sf2", gfx_mapper_pkg::GAME_SF2, gfx_mapper_pkg::LAYER_OBJ, c);
        end
        report_test("captcomm_sf2");
    endtask

    task automatic ghouls_and_dropped();
        gfx_mapper_pkg::code_t c;
        int l;
        int i;
        for (l = 0; l < 4; l++) begin
            for (i = 0; i < 4; i++) begin
                c = random_code();
                c[6] = i[0];
                fetch_and_check("ghouls", gfx_mapper_pkg::GAME_GHOULS, 3'(l), c);
            end
        end
        for (i = 0; i < 8; i++) begin
            apply_fetch(GAME_DINO, random_layer(), random_code());
            check_outputs("dino", 4'h0, 4'hf, 1'b1);
            apply_fetch(GAME_MERCS, random_layer(), random_code());
            check_outputs("mercs", 4'h0, 4'hf, 1'b1);
        end
        report_test("ghouls_dropped");
    endtask

    task automatic hold_on_idle();
        int i;
        // megaman page 10 lands on bank 2
        apply_fetch(gfx_mapper_pkg::GAME_MEGAMAN, gfx_mapper_pkg::LAYER_SCR1, 10'h2c5);
        check_outputs("hold", OFFSET_CFG[2*W +: W], MASK_CFG[2*W +: W], 1'b0);
        for (i = 0; i < 6; i++) begin
            @(posedge clk);
            game  <= i[0] ? GAME_DINO : gfx_mapper_pkg::GAME_STRIDER;
            layer <= random_layer();
            code  <= random_code();
            @(negedge clk);
            check_outputs("hold", OFFSET_CFG[2*W +: W], MASK_CFG[2*W +: W], 1'b0);
        end
        fetch_and_check("hold", gfx_mapper_pkg::GAME_STRIDER, gfx_mapper_pkg::LAYER_SCR3, 10'h13c);
        report_test("hold");
    endtask

    initial begin
        seed        = 32'hbfca;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        enable      = 1'b0;
        game        = '0;
        layer       = '0;
        code        = '0;
        bank_offset = OFFSET_CFG;
        bank_mask   = MASK_CFG;
        wait_reset_release(timed_out);
        if (timed_out) begin
            $display("reset still asserted after %0d cycles", RESET_LIMIT);
            $display("TEST FAILED");
        end else begin
            reset_values();
            megaman_banks();
            strider_forgottn_layers();
            captcomm_sf2_codes();
            ghouls_and_dropped();
            hold_on_idle();
            $display("total %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/gfx_mapper_pkg.sv
hw/pal_eq_region.sv
hw/pal_eq_code.sv
hw/bank_latch.sv
hw/bank_window.sv
hw/gfx_mapper_top.sv
verification/gfx_mapper_tb.sv
